/* Makefile */
# Verilator simulation of the shared system bus

TOP := tb_system_bus
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f build.f -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation PASSED" $(LOG); then \
		echo "test: passed"; \
	else \
		echo "test: failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* build.f */
+incdir+hdl
hdl/bus_pkg.sv
hdl/grant_priority.sv
hdl/bus_arbiter.sv
hdl/bus_master_mux.sv
hdl/system_bus.sv
verif/tb_clock_gen.sv
verif/tb_system_bus.sv

/* hdl/bus_arbiter.sv */
`default_nettype none
`timescale 1ns/1ps

`include "bus_consts.svh"

// Idle/busy arbiter for the shared bus
// Grant is registered and held until the transfer is acknowledged
module bus_arbiter
   import bus_pkg::*;
(
   input  logic     bus_clk,
   input  logic     arst_n,
   input  req_vec_t bus_req,
   input  req_vec_t cntrlr_ack,
   input  req_vec_t grant_next,
   output req_vec_t req_masked,
   output req_vec_t bus_grant,
   output logic     bus_ack
);

   arb_state_t state;
   arb_state_t state_next;
   req_vec_t   grant_d;
   logic       any_req;
   logic       other_pending;

   // Unified acknowledge, any controller ends the transfer
   assign bus_ack = |cntrlr_ack;

   // Owner is hidden from the picker while it holds the bus,
   // so a handover never lands on the same requester
   assign req_masked = (state == arb_busy) ? (bus_req & ~bus_grant) : bus_req;

   assign any_req       = |bus_req;
   assign other_pending = |req_masked;

   // Next state and next grant
   always_comb begin
      state_next = state;
      grant_d    = bus_grant;
      case (state)
         arb_idle: begin
            // Acknowledges seen here do not touch the grant
            if (any_req) begin
               state_next = arb_busy;
               grant_d    = grant_next;
            end
         end
         arb_busy: begin
            if (bus_ack) begin
               if (other_pending) begin
                  // Hand over to the best waiting requester
                  grant_d = grant_next;
               end else begin
                  grant_d    = '0;
                  state_next = arb_idle;
               end
            end
         end
         default: begin
            state_next = arb_idle;
            grant_d    = '0;
         end
      endcase
   end

   // State and grant registers
   always_ff @(posedge bus_clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= arb_idle;
         bus_grant <= '0;
      end else begin
         state     <= state_next;
         bus_grant <= grant_d;
      end
   end

   // Never two owners at once
   a_grant_onehot: assert property (
      @(posedge bus_clk) disable iff (!arst_n)
      $onehot0(bus_grant)
   ) else $error("bus_grant not one-hot: %h", bus_grant);

   // Grant and FSM state agree
   a_grant_state: assert property (
      @(posedge bus_clk) disable iff (!arst_n)
      (bus_grant != '0) == (state == arb_busy)
   ) else $error("bus_grant %h disagrees with state %s", bus_grant, state.name());

   // Owner keeps its request up until the transfer is acknowledged
   a_owner_holds: assert property (
      @(posedge bus_clk) disable iff (!arst_n)
      (state == arb_busy && !bus_ack) |=> |(bus_req & $past(bus_grant))
   ) else $error("owner dropped its request before bus_ack");

endmodule

`default_nettype wire

/* hdl/bus_consts.svh */
`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

// Requesters on the shared bus
// 0 mem, 1 dcache, 2 icache, 3 kbd, 4 dma, 5 spare
`define BUS_MASTERS 6

// Byte address carried on the bus
`define BUS_ADDR_W 32

// Data word carried on the bus
`define BUS_DATA_W 32

`endif

/* hdl/bus_master_mux.sv */
`default_nettype none
`timescale 1ns/1ps

`include "bus_consts.svh"

// Drives the granted requester's address, data and strobe
// onto the shared bus
module bus_master_mux
   import bus_pkg::*;
(
   input  req_vec_t                      bus_grant,
   input  bus_addr_t [`BUS_MASTERS-1:0] master_addr,
   input  bus_data_t [`BUS_MASTERS-1:0] master_data,
   input  req_vec_t                      master_write,
   output bus_addr_t                     bus_addr,
   output bus_data_t                     bus_data,
   output logic                          bus_write
);

   // AND-OR select over the one-hot grant
   // A zero grant leaves every output at zero
   always_comb begin
      bus_addr  = '0;
      bus_data  = '0;
      bus_write = 1'b0;
      for (int i = 0; i < `BUS_MASTERS; i++) begin
         bus_addr  = bus_addr | (master_addr[i] & {`BUS_ADDR_W{bus_grant[i]}});
         bus_data  = bus_data | (master_data[i] & {`BUS_DATA_W{bus_grant[i]}});
         bus_write = bus_write | (master_write[i] & bus_grant[i]);
      end
   end

   // Two grant bits would OR two requesters together on the bus
   always_comb begin
      a_single_grant: assert ($onehot0(bus_grant))
         else $error("mux sees more than one grant bit: %h", bus_grant);
   end

endmodule

`default_nettype wire

/* hdl/bus_pkg.sv */
`default_nettype none

`include "bus_consts.svh"

package bus_pkg;

   // One bit per requester
   // Used for requests, grants and controller acknowledges
   typedef logic [`BUS_MASTERS-1:0] req_vec_t;

   // Shared bus address
   typedef logic [`BUS_ADDR_W-1:0] bus_addr_t;

   // Shared bus data word
   typedef logic [`BUS_DATA_W-1:0] bus_data_t;

   // Arbiter FSM states
   typedef enum logic {
      arb_idle = 1'b0,
      arb_busy = 1'b1
   } arb_state_t;

endpackage

`default_nettype wire

/* hdl/grant_priority.sv */
`default_nettype none
`timescale 1ns/1ps

`include "bus_consts.svh"

// Fixed priority picker, lowest index wins
// Index 0 is the memory controller, so it always comes first
module grant_priority
   import bus_pkg::*;
(
   input  req_vec_t req,
   output req_vec_t grant_next
);

   // Set at bit i when some lower index is already requesting
   req_vec_t taken;

   // Ripple chain from the highest priority requester upward
   // A bit survives only if nothing ahead of it asked
   // All zero when no request is set
   always_comb begin
      taken[0] = 1'b0;
      for (int i = 1; i < `BUS_MASTERS; i++) begin
         taken[i] = taken[i-1] | req[i-1];
      end
      grant_next = req & ~taken;
   end

endmodule

`default_nettype wire

/* hdl/system_bus.sv */
`default_nettype none
`timescale 1ns/1ps

`include "bus_consts.svh"

// Shared system bus top
// Six requesters, one owner at a time
module system_bus
   import bus_pkg::*;
(
   input  logic                          bus_clk,
   input  logic                          arst_n,

   // Requester side
   input  req_vec_t                      bus_req,
   input  bus_addr_t [`BUS_MASTERS-1:0] master_addr,
   input  bus_data_t [`BUS_MASTERS-1:0] master_data,
   input  req_vec_t                      master_write,

   // Slave controller acknowledges, one-cycle pulses
   input  req_vec_t                      cntrlr_ack,

   output req_vec_t                      bus_grant,
   output logic                          bus_ack,

   // Shared bus
   output bus_addr_t                     bus_addr,
   output bus_data_t                     bus_data,
   output logic                          bus_write
);

   // Arbiter to picker and back
   req_vec_t req_masked;
   req_vec_t grant_next;

   grant_priority grant_priority_i (
      .req        (req_masked),
      .grant_next (grant_next)
   );

   bus_arbiter bus_arbiter_i (
      .bus_clk    (bus_clk),
      .arst_n     (arst_n),
      .bus_req    (bus_req),
      .cntrlr_ack (cntrlr_ack),
      .grant_next (grant_next),
      .req_masked (req_masked),
      .bus_grant  (bus_grant),
      .bus_ack    (bus_ack)
   );

   // Bus outputs follow the registered grant
   bus_master_mux bus_master_mux_i (
      .bus_grant    (bus_grant),
      .master_addr  (master_addr),
      .master_data  (master_data),
      .master_write (master_write),
      .bus_addr     (bus_addr),
      .bus_data     (bus_data),
      .bus_write    (bus_write)
   );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/1ps

// Free running bus clock and power-on reset
module tb_clock_gen #(
   parameter int PERIOD_NS    = 10,
   parameter int RESET_CYCLES = 10
) (
   output logic bus_clk,
   output logic arst_n
);

   initial begin
      bus_clk = 1'b0;
      forever #(PERIOD_NS / 2) bus_clk = ~bus_clk;
   end

   // Release on a falling edge, away from the sampling edge
   initial begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge bus_clk);
      @(negedge bus_clk);
      arst_n = 1'b1;
   end

endmodule

`default_nettype wire

/* verif/tb_system_bus.sv */
`default_nettype none
`timescale 1ns/1ps

`include "bus_consts.svh"

module tb_system_bus
   import bus_pkg::*;
();

   localparam int RESET_CYCLES   = 10;
   localparam int DIRECTED_XFERS = 6;
   localparam int RANDOM_XFERS   = 400;
   // Drain may finish one transfer per requester
   localparam int PLANNED_XFERS  = DIRECTED_XFERS + RANDOM_XFERS + `BUS_MASTERS;
   localparam int TIMEOUT_CYCLES = 20 * PLANNED_XFERS + RESET_CYCLES;

   localparam req_vec_t REQ_MEM    = req_vec_t'(1) << 0;
   localparam req_vec_t REQ_ICACHE = req_vec_t'(1) << 2;
   localparam req_vec_t REQ_KBD    = req_vec_t'(1) << 3;
   localparam req_vec_t REQ_DMA    = req_vec_t'(1) << 4;
   localparam req_vec_t REQ_SPARE  = req_vec_t'(1) << 5;

   logic                         bus_clk;
   logic                         arst_n;
   req_vec_t                     bus_req;
   bus_addr_t [`BUS_MASTERS-1:0] master_addr;
   bus_data_t [`BUS_MASTERS-1:0] master_data;
   req_vec_t                     master_write;
   req_vec_t                     cntrlr_ack;
   req_vec_t                     bus_grant;
   logic                         bus_ack;
   bus_addr_t                    bus_addr;
   bus_data_t                    bus_data;
   logic                         bus_write;

   // Reference model state
   req_vec_t  model_grant;
   logic      model_busy;
   req_vec_t  model_next;
   bus_addr_t exp_addr;
   bus_data_t exp_data;
   logic      exp_write;

   // Owners acknowledged at the last edge, released at the next falling edge
   req_vec_t served;
   int       xfer_count;
   int       cycle_count;
   int       check_count;
   int       mismatch_count;
   int       other_count;

   tb_clock_gen #(
      .PERIOD_NS    (10),
      .RESET_CYCLES (RESET_CYCLES)
   ) clock_gen_i (
      .bus_clk (bus_clk),
      .arst_n  (arst_n)
   );

   system_bus system_bus_i (
      .bus_clk      (bus_clk),
      .arst_n       (arst_n),
      .bus_req      (bus_req),
      .master_addr  (master_addr),
      .master_data  (master_data),
      .master_write (master_write),
      .cntrlr_ack   (cntrlr_ack),
      .bus_grant    (bus_grant),
      .bus_ack      (bus_ack),
      .bus_addr     (bus_addr),
      .bus_data     (bus_data),
      .bus_write    (bus_write)
   );

   // Next grant by the arbitration rules
   // Idle takes any request, busy moves only on an acknowledge and skips the owner
   function automatic req_vec_t ref_next_grant(input req_vec_t cur_grant, input logic cur_busy,
                                               input req_vec_t req, input logic ack);
      req_vec_t pending;
      req_vec_t pick;
      pick = '0;
      if (cur_busy && !ack) begin
         pick = cur_grant;
      end else begin
         pending = cur_busy ? (req & ~cur_grant) : req;
         // Walk downward so the lowest index wins
         for (int i = `BUS_MASTERS - 1; i >= 0; i--) begin
            if (pending[i]) begin
               pick    = '0;
               pick[i] = 1'b1;
            end
         end
      end
      return pick;
   endfunction

   function automatic req_vec_t pick_ack();
      return req_vec_t'(1) << $urandom_range(`BUS_MASTERS - 1, 0);
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      check_count++;
      assert (actual === expected)
      else begin
         mismatch_count++;
         $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
      end
   endtask

   task automatic expect_owner(input req_vec_t owner);
      check_value("bus_grant", 32'(bus_grant), 32'(owner));
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge bus_clk);
   endtask

   // Raise requests with fresh payloads, held until served
   task automatic raise_requests(input req_vec_t mask);
      for (int i = 0; i < `BUS_MASTERS; i++) begin
         if (mask[i]) begin
            bus_req[i]      = 1'b1;
            master_addr[i]  = bus_addr_t'($urandom);
            master_data[i]  = bus_data_t'($urandom);
            master_write[i] = ($urandom % 2) == 1;
         end
      end
   endtask

   // Acknowledge the visible owner, then let it drop its request
   task automatic finish_transfer;
      req_vec_t owner;
      owner      = bus_grant;
      cntrlr_ack = pick_ack();
      @(negedge bus_clk);
      cntrlr_ack = '0;
      bus_req    = bus_req & ~owner;
   endtask

   // One falling edge of random traffic
   task automatic random_step(input logic allow_new);
      req_vec_t new_reqs;
      @(negedge bus_clk);
      bus_req  = bus_req & ~served;
      new_reqs = '0;
      for (int i = 0; i < `BUS_MASTERS; i++) begin
         if (allow_new && !bus_req[i] && !served[i] && ($urandom % 4 == 0)) begin
            new_reqs[i] = 1'b1;
         end
      end
      raise_requests(new_reqs);
      served     = '0;
      cntrlr_ack = '0;
      if (bus_grant != '0 && ($urandom % 3 == 0)) begin
         cntrlr_ack = pick_ack();
         served     = bus_grant;
         xfer_count++;
      end
   endtask

   task automatic report_and_finish;
      $display("Checks: %0d, mismatches: %0d, other errors: %0d",
               check_count, mismatch_count, other_count);
      if (mismatch_count == 0 && other_count == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   endtask

   // Compare against the model on every rising edge
   always @(posedge bus_clk) begin
      cycle_count++;
      if (!arst_n) begin
         model_grant = '0;
         model_busy  = 1'b0;
      end else begin
         exp_addr  = '0;
         exp_data  = '0;
         exp_write = 1'b0;
         for (int i = 0; i < `BUS_MASTERS; i++) begin
            if (model_grant[i]) begin
               exp_addr  = master_addr[i];
               exp_data  = master_data[i];
               exp_write = master_write[i];
            end
         end
         check_value("bus_grant", 32'(bus_grant), 32'(model_grant));
         check_value("bus_ack", 32'(bus_ack), 32'(|cntrlr_ack));
         check_value("bus_addr", 32'(bus_addr), 32'(exp_addr));
         check_value("bus_data", 32'(bus_data), 32'(exp_data));
         check_value("bus_write", 32'(bus_write), 32'(exp_write));
         model_next  = ref_next_grant(model_grant, model_busy, bus_req, |cntrlr_ack);
         model_grant = model_next;
         model_busy  = (model_next != '0);
      end
   end

   initial begin
      while (cycle_count < TIMEOUT_CYCLES) @(posedge bus_clk);
      other_count++;
      $display("Error: timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      report_and_finish();
   end

   initial begin
      bus_req        = '0;
      master_addr    = '0;
      master_data    = '0;
      master_write   = '0;
      cntrlr_ack     = '0;
      served         = '0;
      xfer_count     = 0;
      cycle_count    = 0;
      check_count    = 0;
      mismatch_count = 0;
      other_count    = 0;
      void'($urandom(32'hdf5ceae5));

      wait (arst_n === 1'b1);
      wait_cycles(3);
      expect_owner('0);

      // Acknowledge while idle shows on bus_ack only
      cntrlr_ack = REQ_ICACHE;
      @(negedge bus_clk);
      cntrlr_ack = '0;
      wait_cycles(2);
      expect_owner('0);

      // Single request, granted one cycle later
      raise_requests(REQ_KBD);
      @(negedge bus_clk);
      expect_owner(REQ_KBD);
      wait_cycles(2);
      expect_owner(REQ_KBD);
      finish_transfer();
      expect_owner('0);

      // Three at once, served in index order
      raise_requests(REQ_ICACHE | REQ_DMA | REQ_SPARE);
      @(negedge bus_clk);
      expect_owner(REQ_ICACHE);
      finish_transfer();
      expect_owner(REQ_DMA);
      finish_transfer();
      expect_owner(REQ_SPARE);
      finish_transfer();
      expect_owner('0);

      // Memory waits behind the dma owner, no preemption
      raise_requests(REQ_DMA);
      @(negedge bus_clk);
      expect_owner(REQ_DMA);
      raise_requests(REQ_MEM);
      wait_cycles(3);
      expect_owner(REQ_DMA);
      finish_transfer();
      expect_owner(REQ_MEM);
      finish_transfer();
      expect_owner('0);

      while (xfer_count < RANDOM_XFERS) begin
         random_step(1'b1);
      end
      // Serve whoever is still waiting
      while (bus_req != '0 || served != '0) begin
         random_step(1'b0);
      end
      wait_cycles(3);
      report_and_finish();
   end

endmodule

`default_nettype wire
